// File: Makefile
TOP := execTb
OBJ := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f files.f --top-module $(TOP) \
		-Mdir $(OBJ) -o simv
	./$(OBJ)/simv

clean:
	rm -rf $(OBJ)

// File: dv/execTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module execTb;

	localparam int NumOps     = 2000;
	localparam int CycleLimit = NumOps * (`DIV_STEPS + 8);

	typedef struct packed {
		logic [`XLEN-1:0] res;
		logic             taken;
		logic             ovf;
		logic             dbz;
	} expT;

	logic             CLK;
	logic             rst_n;
	logic             inValid;
	logic             inReady;
	aluPkg::opClassT  opClass;
	logic [2:0]       funct3;
	logic             altOp;
	logic [`XLEN-1:0] rs1;
	logic [`XLEN-1:0] rs2;
	logic             outValid;
	logic             outReady;
	logic [`XLEN-1:0] result;
	logic             branchTaken;
	logic             overflow;
	logic             divByZero;

	logic [31:0]      lfsrState = 32'h20ba_a3c4;
	expT              expQ[$];
	logic             seenReady;
	logic             prevValid = 1'b0;
	logic             prevReady = 1'b0;
	logic [`XLEN-1:0] prevResult;
	logic             prevTaken;
	logic             prevOvf;
	logic             prevDbz;
	int               cycleCount = 0;

	tbClock uClock (
		.CLK   (CLK),
		.rst_n (rst_n)
	);

	execUnit uut (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.inValid     (inValid),
		.inReady     (inReady),
		.opClass     (opClass),
		.funct3      (funct3),
		.altOp       (altOp),
		.rs1         (rs1),
		.rs2         (rs2),
		.outValid    (outValid),
		.outReady    (outReady),
		.result      (result),
		.branchTaken (branchTaken),
		.overflow    (overflow),
		.divByZero   (divByZero)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic takeBits(input int n, output logic [31:0] val);
		val = '0;
		for (int k = 0; k < n; k++) begin
			lfsrState = lfsrStep(lfsrState);
			val = {val[30:0], lfsrState[0]};
		end
	endtask

	// Roughly one in five operands is a corner value
	task automatic pickOperand(output logic [`XLEN-1:0] v);
		logic [31:0] r;
		takeBits(8, r);
		if (r[7:0] < 8'd51) begin
			takeBits(2, r);
			case (r[1:0])
				2'd1:    v = '1;
				2'd2:    v = {1'b1, {(`XLEN-1){1'b0}}};
				default: v = '0;
			endcase
		end else begin
			takeBits(`XLEN, v);
		end
	endtask

	function automatic expT modelOp(input aluPkg::opClassT cls, input logic [2:0] f3,
			input logic alt, input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
		expT                     e;
		logic signed [`XLEN-1:0] sa;
		logic signed [`XLEN-1:0] sb;
		logic [2*`XLEN-1:0]      p;
		logic [`XLEN-1:0]        q;
		logic [`XLEN-1:0]        rm;
		e  = '0;
		sa = a;
		sb = b;
		case (cls)
			aluPkg::clsAlu: begin
				case (f3)
					3'd0: begin
						if (alt) begin
							e.res = a - b;
							e.ovf = (a[`XLEN-1] != b[`XLEN-1]) && (e.res[`XLEN-1] != a[`XLEN-1]);
						end else begin
							e.res = a + b;
							e.ovf = (a[`XLEN-1] == b[`XLEN-1]) && (e.res[`XLEN-1] != a[`XLEN-1]);
						end
					end
					3'd1:    e.res = a << b[4:0];
					3'd2:    e.res = (sa < sb) ? 1 : 0;
					3'd3:    e.res = (a < b) ? 1 : 0;
					3'd4:    e.res = a ^ b;
					3'd5: begin
						if (alt) begin
							e.res = sa >>> b[4:0];
						end else begin
							e.res = a >> b[4:0];
						end
					end
					3'd6:    e.res = a | b;
					default: e.res = a & b;
				endcase
			end
			aluPkg::clsMul: begin
				case (f3)
					isaPkg::mulhu:  p = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
					isaPkg::mulhsu: p = {{`XLEN{a[`XLEN-1]}}, a} * {{`XLEN{1'b0}}, b};
					default:        p = {{`XLEN{a[`XLEN-1]}}, a} * {{`XLEN{b[`XLEN-1]}}, b};
				endcase
				e.res = (f3 == isaPkg::mul) ? p[`XLEN-1:0] : p[2*`XLEN-1:`XLEN];
			end
			aluPkg::clsDiv: begin
				if (b == '0) begin
					q     = '1;
					rm    = a;
					e.dbz = 1'b1;
				end else if ((f3 == isaPkg::div || f3 == isaPkg::rem)
						&& a == {1'b1, {(`XLEN-1){1'b0}}} && b == '1) begin
					q  = a;
					rm = '0;
				end else if (f3 == isaPkg::div || f3 == isaPkg::rem) begin
					q  = sa / sb;
					rm = sa % sb;
				end else begin
					q  = a / b;
					rm = a % b;
				end
				e.res = (f3 == isaPkg::rem || f3 == isaPkg::remu) ? rm : q;
			end
			default: begin
				case (f3)
					isaPkg::beq:  e.taken = a == b;
					isaPkg::bne:  e.taken = a != b;
					isaPkg::blt:  e.taken = sa < sb;
					isaPkg::bge:  e.taken = sa >= sb;
					isaPkg::bltu: e.taken = a < b;
					isaPkg::bgeu: e.taken = a >= b;
					default:      e.taken = 1'b0;
				endcase
			end
		endcase
		return e;
	endfunction

	task automatic checkWord(input string name, input logic [`XLEN-1:0] got,
			input logic [`XLEN-1:0] want);
		assert (got === want) else begin
			$display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, want);
			$display("Simulation failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic want);
		assert (got === want) else begin
			$display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, want);
			$display("Simulation failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	// Called at the rising edge, before the DUT registers move
	task automatic checkOutputs();
		expT want;
		if (prevValid && !prevReady) begin
			checkBit("outValid while stalled", outValid, 1'b1);
			checkWord("result while stalled", result, prevResult);
			checkBit("branchTaken while stalled", branchTaken, prevTaken);
			checkBit("overflow while stalled", overflow, prevOvf);
			checkBit("divByZero while stalled", divByZero, prevDbz);
		end
		if (outValid && outReady) begin
			assert (expQ.size() > 0) else begin
				$display("At %0t ns a result was handed out with no operation pending", $time);
				$display("Simulation failed");
				$fatal(1, "stopped at first error");
			end
			want = expQ.pop_front();
			checkWord("result", result, want.res);
			checkBit("branchTaken", branchTaken, want.taken);
			checkBit("overflow", overflow, want.ovf);
			checkBit("divByZero", divByZero, want.dbz);
		end
		prevValid  = outValid;
		prevReady  = outReady;
		prevResult = result;
		prevTaken  = branchTaken;
		prevOvf    = overflow;
		prevDbz    = divByZero;
	endtask

	// Sample at the edge, then drive a random outReady 1 ns later
	task automatic nextCycle();
		logic [31:0] r;
		@(posedge CLK);
		seenReady = inReady;
		checkOutputs();
		#1;
		takeBits(2, r);
		outReady = r[1:0] != 2'd0;
	endtask

	task automatic makeOp();
		logic [31:0] r;
		takeBits(2, r);
		opClass = aluPkg::opClassT'({1'b0, r[1:0]});
		altOp   = 1'b0;
		case (opClass)
			aluPkg::clsAlu: begin
				takeBits(3, r);
				funct3 = r[2:0];
				if (funct3 == 3'd0 || funct3 == 3'd5) begin
					takeBits(1, r);
					altOp = r[0];
				end
			end
			aluPkg::clsMul: begin
				takeBits(2, r);
				funct3 = {1'b0, r[1:0]};
			end
			aluPkg::clsDiv: begin
				takeBits(2, r);
				funct3 = {1'b1, r[1:0]};
			end
			default: begin
				takeBits(3, r);
				// Only the six real branch codes
				case (r[2:0])
					3'd0, 3'd6: funct3 = isaPkg::beq;
					3'd1, 3'd7: funct3 = isaPkg::bne;
					3'd2:       funct3 = isaPkg::blt;
					3'd3:       funct3 = isaPkg::bge;
					3'd4:       funct3 = isaPkg::bltu;
					default:    funct3 = isaPkg::bgeu;
				endcase
			end
		endcase
		pickOperand(rs1);
		pickOperand(rs2);
	endtask

	initial begin
		logic [31:0] r;
		logic        accepted;
		inValid  = 1'b0;
		opClass  = aluPkg::clsAlu;
		funct3   = 3'd0;
		altOp    = 1'b0;
		rs1      = '0;
		rs2      = '0;
		outReady = 1'b0;

		wait (rst_n === 1'b1);
		nextCycle();
		checkBit("outValid after reset", outValid, 1'b0);
		checkBit("inReady after reset", seenReady, 1'b1);

		for (int i = 0; i < NumOps; i++) begin
			takeBits(2, r);
			while (r[1:0] == 2'd0) begin
				inValid = 1'b0;
				nextCycle();
				takeBits(2, r);
			end
			makeOp();
			inValid  = 1'b1;
			accepted = 1'b0;
			while (!accepted) begin
				nextCycle();
				accepted = seenReady;
			end
			expQ.push_back(modelOp(opClass, funct3, altOp, rs1, rs2));
		end
		inValid = 1'b0;

		while (expQ.size() != 0) begin
			nextCycle();
		end
		// A few idle cycles catch any extra result
		repeat (4) nextCycle();

		$display("Simulation passed");
		$finish;
	end

	always @(posedge CLK) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("Timeout: %0d cycles passed and %0d results were still outstanding",
				cycleCount, expQ.size());
			$display("Simulation failed");
			$fatal(1, "run hit the cycle limit");
		end
	end

endmodule

`default_nettype wire

// File: dv/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
	output logic CLK,
	output logic rst_n
);

	// 100 ns period
	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// Reset held for 8 rising edges, released just after the last one
	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge CLK);
		#1 rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+hw
hw/isaPkg.sv
hw/aluPkg.sv
hw/intOps.sv
hw/mulUnit.sv
hw/divUnit.sv
hw/execUnit.sv
dv/tbClock.sv
dv/execTb.sv

// File: hw/aluPkg.sv
`default_nettype none

package aluPkg;

	// Which unit an operation goes to
	typedef enum logic [2:0] {
		clsAlu    = 3'd0,
		clsMul    = 3'd1,
		clsDiv    = 3'd2,
		clsBranch = 3'd3
	} opClassT;

endpackage

`default_nettype wire

// File: hw/alu_consts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// Datapath width
`define XLEN 32

// One divider iteration per quotient bit
`define DIV_STEPS `XLEN

`endif

// File: hw/divUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module divUnit (
	input  logic             CLK,
	input  logic             rst_n,
	input  logic             start,
	input  isaPkg::divF3T    funct3,
	input  logic [`XLEN-1:0] dividend,
	input  logic [`XLEN-1:0] divisor,
	input  logic             ack,
	output logic             busy,
	output logic             done,
	output logic [`XLEN-1:0] quotientOrRem,
	output logic             divByZero
);

	localparam int Msb  = `XLEN - 1;
	localparam int CntW = $clog2(`DIV_STEPS + 1);

	logic            running;
	logic [CntW-1:0] count;
	logic            isSigned;
	logic            negA;
	logic            negB;
	logic [Msb:0]    absA;
	logic [Msb:0]    absB;
	logic [Msb:0]    quoAcc;
	logic [Msb:0]    remAcc;
	logic [Msb:0]    den;
	logic            wantRem;
	logic            negQuo;
	logic            negRem;
	logic [`XLEN:0]  partial;
	logic            fits;

	assign isSigned = funct3 == isaPkg::div || funct3 == isaPkg::rem;
	assign negA = isSigned && dividend[Msb];
	assign negB = isSigned && divisor[Msb];
	assign absA = negA ? -dividend : dividend;
	assign absB = negB ? -divisor : divisor;

	// Next dividend bit shifted into the partial remainder
	assign partial = {remAcc, quoAcc[Msb]};
	assign fits = partial >= {1'b0, den};

	// Held busy until the result is taken
	assign busy = running || done;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			done    <= 1'b0;
			count   <= '0;
		end else if (start && !busy) begin
			running <= 1'b1;
			count   <= CntW'(`DIV_STEPS);
		end else if (running) begin
			if (count != '0) begin
				count <= count - 1'b1;
			end else begin
				running <= 1'b0;
				done    <= 1'b1;
			end
		end else if (done && ack) begin
			done <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (start && !busy) begin
			quoAcc    <= absA;
			remAcc    <= '0;
			den       <= absB;
			wantRem   <= funct3 == isaPkg::rem || funct3 == isaPkg::remu;
			// Zero divisor keeps the all-ones quotient
			negQuo    <= (negA ^ negB) && divisor != '0;
			negRem    <= negA;
			divByZero <= divisor == '0;
		end else if (running) begin
			if (count != '0) begin
				remAcc <= fits ? partial[Msb:0] - den : partial[Msb:0];
				quoAcc <= {quoAcc[Msb-1:0], fits};
			end else if (wantRem) begin
				quotientOrRem <= negRem ? -remAcc : remAcc;
			end else begin
				quotientOrRem <= negQuo ? -quoAcc : quoAcc;
			end
		end
	end

	assert property (@(posedge CLK) disable iff (!rst_n) busy |-> !start)
		else $error("divUnit started while busy");

	assert property (@(posedge CLK) disable iff (!rst_n) done && !ack |=> done)
		else $error("divUnit dropped done without ack");

endmodule

`default_nettype wire

// File: hw/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module execUnit (
	input  logic             CLK,
	input  logic             rst_n,
	input  logic             inValid,
	output logic             inReady,
	input  aluPkg::opClassT  opClass,
	input  logic [2:0]       funct3,
	input  logic             altOp,
	input  logic [`XLEN-1:0] rs1,
	input  logic [`XLEN-1:0] rs2,
	output logic             outValid,
	input  logic             outReady,
	output logic [`XLEN-1:0] result,
	output logic             branchTaken,
	output logic             overflow,
	output logic             divByZero
);

	logic             selAlu;
	logic             selMul;
	logic             selDiv;
	logic             selBranch;
	logic             accept;
	logic             regFree;
	logic             loadOp;
	logic [`XLEN-1:0] aluResult;
	logic             aluOvf;
	logic             aluTaken;
	logic [`XLEN-1:0] product;
	logic             divStart;
	logic             divBusy;
	logic             divDone;
	logic             divAck;
	logic [`XLEN-1:0] divResult;
	logic             divZero;

	// Class code to unit enables
	always_comb begin
		selAlu    = 1'b0;
		selMul    = 1'b0;
		selDiv    = 1'b0;
		selBranch = 1'b0;
		case (opClass)
			aluPkg::clsAlu:    selAlu = 1'b1;
			aluPkg::clsMul:    selMul = 1'b1;
			aluPkg::clsDiv:    selDiv = 1'b1;
			aluPkg::clsBranch: selBranch = 1'b1;
			default:           selAlu = 1'b0;
		endcase
	end

	assign regFree  = !outValid || outReady;
	assign inReady  = regFree && !divBusy;
	assign accept   = inValid && inReady;
	assign loadOp   = accept && (selAlu || selMul || selBranch);
	assign divStart = accept && selDiv;
	// Divider owns the output register once it finishes
	assign divAck   = divDone && regFree;

	intOps uIntOps (
		.funct3      (isaPkg::aluF3T'(funct3)),
		.altOp       (altOp),
		.isBranch    (selBranch),
		.rs1         (rs1),
		.rs2         (rs2),
		.aluResult   (aluResult),
		.overflow    (aluOvf),
		.branchTaken (aluTaken)
	);

	mulUnit uMulUnit (
		.funct3  (isaPkg::mulF3T'(funct3)),
		.rs1     (rs1),
		.rs2     (rs2),
		.product (product)
	);

	divUnit uDivUnit (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.start         (divStart),
		.funct3        (isaPkg::divF3T'(funct3)),
		.dividend      (rs1),
		.divisor       (rs2),
		.ack           (divAck),
		.busy          (divBusy),
		.done          (divDone),
		.quotientOrRem (divResult),
		.divByZero     (divZero)
	);

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			outValid <= 1'b0;
		end else if (loadOp || divAck) begin
			outValid <= 1'b1;
		end else if (outReady) begin
			outValid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (loadOp) begin
			result      <= selMul ? product : aluResult;
			branchTaken <= aluTaken;
			overflow    <= selAlu && aluOvf;
			divByZero   <= 1'b0;
		end else if (divAck) begin
			result      <= divResult;
			branchTaken <= 1'b0;
			overflow    <= 1'b0;
			divByZero   <= divZero;
		end
	end

	assert property (@(posedge CLK) disable iff (!rst_n)
		outValid && !outReady |=> outValid && $stable(result) && $stable(branchTaken)
			&& $stable(overflow) && $stable(divByZero))
		else $error("execUnit output changed under back-pressure");

	// No new operation while a division is in flight
	assert property (@(posedge CLK) disable iff (!rst_n) divStart |=> !inReady)
		else $error("execUnit ready right after a division started");

endmodule

`default_nettype wire

// File: hw/intOps.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module intOps (
	input  isaPkg::aluF3T    funct3,
	input  logic             altOp,
	input  logic             isBranch,
	input  logic [`XLEN-1:0] rs1,
	input  logic [`XLEN-1:0] rs2,
	output logic [`XLEN-1:0] aluResult,
	output logic             overflow,
	output logic             branchTaken
);

	localparam int Msb = `XLEN - 1;

	logic           doSub;
	logic [Msb:0]   opB;
	logic [`XLEN:0] sum;
	logic           addOvf;
	logic           ltSigned;
	logic           ltUnsigned;
	logic           isEqual;
	logic [4:0]     shamt;
	logic [Msb:0]   shiftRight;
	isaPkg::brF3T   brCode;

	// Compares and branches always subtract
	assign doSub = isBranch
		|| (funct3 == isaPkg::aluAddSub && altOp)
		|| funct3 == isaPkg::aluSlt
		|| funct3 == isaPkg::aluSltu;

	// Single carry chain, invert and carry in for subtract
	assign opB = rs2 ^ {`XLEN{doSub}};
	assign sum = {1'b0, rs1} + {1'b0, opB} + {{`XLEN{1'b0}}, doSub};

	assign addOvf = (rs1[Msb] == opB[Msb]) && (sum[Msb] != rs1[Msb]);

	// No carry out means a borrow
	assign ltUnsigned = !sum[`XLEN];
	assign ltSigned   = sum[Msb] ^ addOvf;
	assign isEqual    = sum[Msb:0] == '0;

	assign shamt = rs2[4:0];
	assign shiftRight = altOp ? `XLEN'($signed(rs1) >>> shamt) : rs1 >> shamt;

	assign brCode = isaPkg::brF3T'(funct3);

	always_comb begin
		aluResult = '0;
		if (!isBranch) begin
			case (funct3)
				isaPkg::aluAddSub: aluResult = sum[Msb:0];
				isaPkg::aluSll:    aluResult = rs1 << shamt;
				isaPkg::aluSlt:    aluResult = {{Msb{1'b0}}, ltSigned};
				isaPkg::aluSltu:   aluResult = {{Msb{1'b0}}, ltUnsigned};
				isaPkg::aluXor:    aluResult = rs1 ^ rs2;
				isaPkg::aluSrlSra: aluResult = shiftRight;
				isaPkg::aluOr:     aluResult = rs1 | rs2;
				isaPkg::aluAnd:    aluResult = rs1 & rs2;
				default:           aluResult = '0;
			endcase
		end
	end

	assign overflow = !isBranch && funct3 == isaPkg::aluAddSub && addOvf;

	always_comb begin
		branchTaken = 1'b0;
		if (isBranch) begin
			case (brCode)
				isaPkg::beq:  branchTaken = isEqual;
				isaPkg::bne:  branchTaken = !isEqual;
				isaPkg::blt:  branchTaken = ltSigned;
				isaPkg::bge:  branchTaken = !ltSigned;
				isaPkg::bltu: branchTaken = ltUnsigned;
				isaPkg::bgeu: branchTaken = !ltUnsigned;
				// 010 and 011 are not branches
				default:      branchTaken = 1'b0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/isaPkg.sv
`default_nettype none

package isaPkg;

	// RV32I register-register funct3
	typedef enum logic [2:0] {
		aluAddSub = 3'b000,
		aluSll    = 3'b001,
		aluSlt    = 3'b010,
		aluSltu   = 3'b011,
		aluXor    = 3'b100,
		aluSrlSra = 3'b101,
		aluOr     = 3'b110,
		aluAnd    = 3'b111
	} aluF3T;

	// Conditional branches
	typedef enum logic [2:0] {
		beq  = 3'b000,
		bne  = 3'b001,
		blt  = 3'b100,
		bge  = 3'b101,
		bltu = 3'b110,
		bgeu = 3'b111
	} brF3T;

	// M extension, multiply half
	typedef enum logic [2:0] {
		mul    = 3'b000,
		mulh   = 3'b001,
		mulhsu = 3'b010,
		mulhu  = 3'b011
	} mulF3T;

	// M extension, divide half
	typedef enum logic [2:0] {
		div  = 3'b100,
		divu = 3'b101,
		rem  = 3'b110,
		remu = 3'b111
	} divF3T;

endpackage

`default_nettype wire

// File: hw/mulUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module mulUnit (
	input  isaPkg::mulF3T    funct3,
	input  logic [`XLEN-1:0] rs1,
	input  logic [`XLEN-1:0] rs2,
	output logic [`XLEN-1:0] product
);

	localparam int Msb = `XLEN - 1;

	logic                       signA;
	logic                       signB;
	logic [`XLEN:0]             opA;
	logic [`XLEN:0]             opB;
	logic signed [2*`XLEN+1:0]  full;

	// mulhu is the only variant with unsigned rs1
	assign signA = funct3 != isaPkg::mulhu;
	assign signB = funct3 == isaPkg::mul || funct3 == isaPkg::mulh;

	// 33 bits cover both signed and unsigned operands
	assign opA = {signA & rs1[Msb], rs1};
	assign opB = {signB & rs2[Msb], rs2};

	assign full = $signed(opA) * $signed(opB);

	// Low word is the same for every signedness
	assign product = (funct3 == isaPkg::mul) ? full[Msb:0] : full[2*`XLEN-1:`XLEN];

endmodule

`default_nettype wire
